// File: include/rv_lite_consts.svh
// rv_lite core constants: data width, reset PC, memory depth, opcodes and special words

`ifndef RV_LITE_CONSTS_SVH
`define RV_LITE_CONSTS_SVH

// data path width
`define RV_XLEN 64

// first instruction fetched after reset
`define RV_PC_START 64'h0000_0000_8000_0000

// instruction memory word address width, 256 words
`define RV_IMEM_AW 8

// major opcodes, inst[6:0]
`define RV_OP_LUI 7'h37
`define RV_OP_JAL 7'h6f
`define RV_OP_IMM 7'h13
`define RV_OP_REG 7'h33
`define RV_OP_BRANCH 7'h63

// custom opcode, halts the core with a0 as code
`define RV_OP_TRAP 7'h6b

// prints the low byte of a0
`define RV_INST_PUTCH 32'h0000_0007

`endif

// File: hw/rv_lite_pkg.sv
// rv_lite shared types: register word, instruction word, phase and ALU operation

`include "rv_lite_consts.svh"

package rv_lite_pkg;

  // one architectural register value
  typedef logic [`RV_XLEN-1:0] xword_t;

  // raw 32-bit instruction
  typedef logic [31:0] inst_t;

  // instruction phases, stepped in order by the fetch unit
  typedef enum logic [1:0] {
    PH_FETCH  = 2'd0,
    PH_DECODE = 2'd1,
    PH_EXEC   = 2'd2,
    PH_WB     = 2'd3
  } phase_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SLT    = 4'd7,
    // result is operand b, used by LUI
    ALU_PASS_B = 4'd8
  } alu_op_e;

endpackage

// File: hw/fetch_unit.sv
// fetch unit: phase sequencer, program counter and loadable instruction memory

`timescale 1ns/1ns

`include "rv_lite_consts.svh"

module fetch_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       run_i,
  input  logic                       halt_i,
  input  logic                       imem_we_i,
  input  logic [`RV_IMEM_AW-1:0]     imem_addr_i,
  input  rv_lite_pkg::inst_t         imem_data_i,
  input  rv_lite_pkg::xword_t        next_pc_i,
  output rv_lite_pkg::phase_e        phase_o,
  output rv_lite_pkg::xword_t        pc_o,
  output rv_lite_pkg::inst_t         inst_o
);

  rv_lite_pkg::inst_t   imem [2**`RV_IMEM_AW];
  rv_lite_pkg::phase_e  phase_q;
  rv_lite_pkg::xword_t  pc_q;
  rv_lite_pkg::inst_t   inst_q;
  logic                 advance;

  // only the fetch phase can hold; everything after it runs to completion
  assign advance = (phase_q != rv_lite_pkg::PH_FETCH) || (run_i && !halt_i);

  // loaded by the testbench while the core is stopped
  always_ff @(posedge clock) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      phase_q <= rv_lite_pkg::PH_FETCH;
    end else if (advance) begin
      phase_q <= rv_lite_pkg::phase_e'(phase_q + 2'd1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= `RV_PC_START;
    end else if (phase_q == rv_lite_pkg::PH_WB) begin
      pc_q <= next_pc_i;
    end
  end

  // word index wraps at the memory depth
  always_ff @(posedge clock) begin
    if (phase_q == rv_lite_pkg::PH_FETCH && advance) begin
      inst_q <= imem[pc_q[`RV_IMEM_AW+1:2]];
    end
  end

  assign phase_o = phase_q;
  assign pc_o    = pc_q;
  assign inst_o  = inst_q;

  // a trap seen at commit must freeze the sequencer at the boundary
  halt_freezes_phase: assert property (
    @(posedge clock) disable iff (reset)
    halt_i |=> phase_q == rv_lite_pkg::PH_FETCH
  ) else $error("phase left PH_FETCH while halted");

endmodule

// File: hw/decode_unit.sv
// decode unit: field split, immediates, operand select and branch target, registered in decode

`timescale 1ns/1ns

`include "rv_lite_consts.svh"

module decode_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  rv_lite_pkg::phase_e    phase_i,
  input  rv_lite_pkg::xword_t    pc_i,
  input  rv_lite_pkg::inst_t     inst_i,
  output logic [4:0]             rs1_addr_o,
  output logic [4:0]             rs2_addr_o,
  input  rv_lite_pkg::xword_t    rs1_data_i,
  input  rv_lite_pkg::xword_t    rs2_data_i,
  output rv_lite_pkg::alu_op_e   alu_op_o,
  output rv_lite_pkg::xword_t    op_a_o,
  output rv_lite_pkg::xword_t    op_b_o,
  output rv_lite_pkg::xword_t    br_a_o,
  output rv_lite_pkg::xword_t    br_b_o,
  output logic                   is_branch_o,
  output logic                   is_jal_o,
  output logic                   br_ne_o,
  output rv_lite_pkg::xword_t    target_o,
  output logic [4:0]             rd_o,
  output logic                   rd_wen_o
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_lite_pkg::xword_t  imm_i, imm_u, imm_b, imm_j;
  rv_lite_pkg::alu_op_e alu_op_d;
  rv_lite_pkg::xword_t  op_a_d, op_b_d, target_d;
  logic                 is_branch_d, is_jal_d, wen_d;

  assign opcode     = inst_i[6:0];
  assign funct3     = inst_i[14:12];
  assign funct7     = inst_i[31:25];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  // sign-extended immediates
  assign imm_i = rv_lite_pkg::xword_t'(signed'(inst_i[31:20]));
  assign imm_u = rv_lite_pkg::xword_t'(signed'({inst_i[31:12], 12'b0}));
  assign imm_b = rv_lite_pkg::xword_t'(signed'({inst_i[31], inst_i[7], inst_i[30:25],
                                                inst_i[11:8], 1'b0}));
  assign imm_j = rv_lite_pkg::xword_t'(signed'({inst_i[31], inst_i[19:12], inst_i[20],
                                                inst_i[30:21], 1'b0}));

  always_comb begin
    alu_op_d    = rv_lite_pkg::ALU_ADD;
    op_a_d      = rs1_data_i;
    op_b_d      = imm_i;
    target_d    = pc_i + imm_b;
    is_branch_d = 1'b0;
    is_jal_d    = 1'b0;
    wen_d       = 1'b0;
    case (opcode)
      `RV_OP_LUI: begin
        alu_op_d = rv_lite_pkg::ALU_PASS_B;
        op_b_d   = imm_u;
        wen_d    = 1'b1;
      end
      `RV_OP_JAL: begin
        // link value pc+4 comes out of the adder
        op_a_d   = pc_i;
        op_b_d   = rv_lite_pkg::xword_t'(4);
        target_d = pc_i + imm_j;
        is_jal_d = 1'b1;
        wen_d    = 1'b1;
      end
      `RV_OP_IMM: begin
        wen_d = 1'b1;
        case (funct3)
          3'b000: alu_op_d = rv_lite_pkg::ALU_ADD;
          3'b100: alu_op_d = rv_lite_pkg::ALU_XOR;
          3'b110: alu_op_d = rv_lite_pkg::ALU_OR;
          3'b111: alu_op_d = rv_lite_pkg::ALU_AND;
          3'b001: begin
            // rv64 slli keeps a 6-bit shamt
            alu_op_d = rv_lite_pkg::ALU_SLL;
            wen_d    = (funct7[6:1] == 6'b0);
          end
          default: wen_d = 1'b0;
        endcase
      end
      `RV_OP_REG: begin
        op_b_d = rs2_data_i;
        wen_d  = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op_d = rv_lite_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_op_d = rv_lite_pkg::ALU_SUB;
          {7'h00, 3'b111}: alu_op_d = rv_lite_pkg::ALU_AND;
          {7'h00, 3'b110}: alu_op_d = rv_lite_pkg::ALU_OR;
          {7'h00, 3'b100}: alu_op_d = rv_lite_pkg::ALU_XOR;
          {7'h00, 3'b001}: alu_op_d = rv_lite_pkg::ALU_SLL;
          {7'h00, 3'b101}: alu_op_d = rv_lite_pkg::ALU_SRL;
          {7'h00, 3'b010}: alu_op_d = rv_lite_pkg::ALU_SLT;
          default: wen_d = 1'b0;
        endcase
      end
      // beq and bne only
      `RV_OP_BRANCH: is_branch_d = (funct3[2:1] == 2'b00);
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      is_branch_o <= 1'b0;
      is_jal_o    <= 1'b0;
      rd_wen_o    <= 1'b0;
    end else if (phase_i == rv_lite_pkg::PH_DECODE) begin
      is_branch_o <= is_branch_d;
      is_jal_o    <= is_jal_d;
      // x0 writes are dropped here, never reach commit
      rd_wen_o    <= wen_d && (inst_i[11:7] != 5'd0);
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == rv_lite_pkg::PH_DECODE) begin
      alu_op_o <= alu_op_d;
      op_a_o   <= op_a_d;
      op_b_o   <= op_b_d;
      br_a_o   <= rs1_data_i;
      br_b_o   <= rs2_data_i;
      br_ne_o  <= funct3[0];
      target_o <= target_d;
      rd_o     <= inst_i[11:7];
    end
  end

endmodule

// File: hw/regfile.sv
// integer register file, 32 x 64 bits, two async reads, one sync write, x0 reads zero

`timescale 1ns/1ns

module regfile (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [4:0]           rs1_addr_i,
  input  logic [4:0]           rs2_addr_i,
  output rv_lite_pkg::xword_t  rs1_data_o,
  output rv_lite_pkg::xword_t  rs2_data_o,
  input  logic [4:0]           rd_i,
  input  logic                 rd_wen_i,
  input  rv_lite_pkg::xword_t  rd_wdata_i,
  output rv_lite_pkg::xword_t  a0_o
);

  rv_lite_pkg::xword_t regs [32];

  // architectural state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= rd_wdata_i;
    end
  end

  // x0 forced on the read side as well
  always_comb begin
    rs1_data_o = regs[rs1_addr_i];
    rs2_data_o = regs[rs2_addr_i];
    if (rs1_addr_i == 5'd0) begin
      rs1_data_o = '0;
    end
    if (rs2_addr_i == 5'd0) begin
      rs2_data_o = '0;
    end
  end

  // a0, read by putch and trap
  assign a0_o = regs[10];

endmodule

// File: hw/execute_unit.sv
// execute unit that computes the ALU result and resolves BEQ and BNE into the next PC

`timescale 1ns/1ns

module execute_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  rv_lite_pkg::phase_e    phase_i,
  input  rv_lite_pkg::xword_t    pc_i,
  input  rv_lite_pkg::alu_op_e   alu_op_i,
  input  rv_lite_pkg::xword_t    op_a_i,
  input  rv_lite_pkg::xword_t    op_b_i,
  input  rv_lite_pkg::xword_t    br_a_i,
  input  rv_lite_pkg::xword_t    br_b_i,
  input  logic                   is_branch_i,
  input  logic                   is_jal_i,
  input  logic                   br_ne_i,
  input  rv_lite_pkg::xword_t    target_i,
  output rv_lite_pkg::xword_t    result_o,
  output rv_lite_pkg::xword_t    next_pc_o
);

  rv_lite_pkg::xword_t alu_out;
  logic [5:0]          shamt;
  logic                br_eq;
  logic                taken;
  logic                redirect;

  assign shamt = op_b_i[5:0];

  always_comb begin
    case (alu_op_i)
      rv_lite_pkg::ALU_ADD:    alu_out = op_a_i + op_b_i;
      rv_lite_pkg::ALU_SUB:    alu_out = op_a_i - op_b_i;
      rv_lite_pkg::ALU_AND:    alu_out = op_a_i & op_b_i;
      rv_lite_pkg::ALU_OR:     alu_out = op_a_i | op_b_i;
      rv_lite_pkg::ALU_XOR:    alu_out = op_a_i ^ op_b_i;
      rv_lite_pkg::ALU_SLL:    alu_out = op_a_i << shamt;
      rv_lite_pkg::ALU_SRL:    alu_out = op_a_i >> shamt;
      // signed compare
      rv_lite_pkg::ALU_SLT:    alu_out = rv_lite_pkg::xword_t'($signed(op_a_i) < $signed(op_b_i));
      rv_lite_pkg::ALU_PASS_B: alu_out = op_b_i;
      default:                 alu_out = '0;
    endcase
  end

  assign br_eq    = (br_a_i == br_b_i);
  assign taken    = is_branch_i && (br_ne_i ? !br_eq : br_eq);
  assign redirect = taken || is_jal_i;

  // target on a taken branch or jal and pc + 4 otherwise
  always_ff @(posedge clock) begin
    if (reset) begin
      next_pc_o <= '0;
    end else if (phase_i == rv_lite_pkg::PH_EXEC) begin
      next_pc_o <= redirect ? target_i : pc_i + rv_lite_pkg::xword_t'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == rv_lite_pkg::PH_EXEC) begin
      result_o <= alu_out;
    end
  end

endmodule

// File: hw/commit_unit.sv
// commit unit: register writeback, commit record, putch strobe, trap latch and instruction count

`timescale 1ns/1ns

`include "rv_lite_consts.svh"

module commit_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  rv_lite_pkg::phase_e   phase_i,
  input  rv_lite_pkg::xword_t   pc_i,
  input  rv_lite_pkg::inst_t    inst_i,
  input  logic [4:0]            rd_i,
  input  logic                  rd_wen_i,
  input  rv_lite_pkg::xword_t   result_i,
  input  rv_lite_pkg::xword_t   a0_i,
  output logic                  rf_wen_o,
  output rv_lite_pkg::xword_t   rf_wdata_o,
  output logic                  halt_o,
  output logic                  commit_valid_o,
  output rv_lite_pkg::xword_t   commit_pc_o,
  output rv_lite_pkg::inst_t    commit_inst_o,
  output logic                  commit_wen_o,
  output logic [7:0]            commit_wdest_o,
  output rv_lite_pkg::xword_t   commit_wdata_o,
  output logic                  putch_valid_o,
  output logic [7:0]            putch_char_o,
  output logic                  trap_o,
  output logic [7:0]            trap_code_o,
  output rv_lite_pkg::xword_t   instr_count_o
);

  logic wb;
  logic is_putch;
  logic is_trap;

  assign wb       = (phase_i == rv_lite_pkg::PH_WB) && !trap_o;
  assign is_putch = (inst_i == `RV_INST_PUTCH);
  assign is_trap  = (inst_i[6:0] == `RV_OP_TRAP);

  // write lands at the end of the wb cycle
  assign rf_wen_o   = wb && rd_wen_i;
  assign rf_wdata_o = result_i;
  assign halt_o     = trap_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid_o <= 1'b0;
      commit_wen_o   <= 1'b0;
      putch_valid_o  <= 1'b0;
      trap_o         <= 1'b0;
      instr_count_o  <= '0;
    end else begin
      commit_valid_o <= wb;
      commit_wen_o   <= rf_wen_o;
      putch_valid_o  <= wb && is_putch;
      if (wb && is_trap) begin
        trap_o <= 1'b1;
      end
      if (wb) begin
        instr_count_o <= instr_count_o + rv_lite_pkg::xword_t'(1);
      end
    end
  end

  // commit record and event payloads
  always_ff @(posedge clock) begin
    if (wb) begin
      commit_pc_o    <= pc_i;
      commit_inst_o  <= inst_i;
      commit_wdest_o <= {3'b0, rd_i};
      commit_wdata_o <= rd_wen_i ? result_i : '0;
      putch_char_o   <= a0_i[7:0];
    end
    if (wb && is_trap) begin
      trap_code_o <= a0_i[7:0];
    end
  end

  // decode drops x0 destinations before they get here
  no_x0_commit: assert property (
    @(posedge clock) disable iff (reset)
    commit_wen_o |-> commit_wdest_o != 8'd0
  ) else $error("commit wrote x0");

endmodule

// File: hw/rv_lite_top.sv
// rv_lite core top level: fetch, decode, register file, execute and commit

`timescale 1ns/1ns

`include "rv_lite_consts.svh"

module rv_lite_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    run_i,
  input  logic                    imem_we_i,
  input  logic [`RV_IMEM_AW-1:0]  imem_addr_i,
  input  rv_lite_pkg::inst_t      imem_data_i,
  output logic                    commit_valid_o,
  output rv_lite_pkg::xword_t     commit_pc_o,
  output rv_lite_pkg::inst_t      commit_inst_o,
  output logic                    commit_wen_o,
  output logic [7:0]              commit_wdest_o,
  output rv_lite_pkg::xword_t     commit_wdata_o,
  output logic                    putch_valid_o,
  output logic [7:0]              putch_char_o,
  output logic                    trap_o,
  output logic [7:0]              trap_code_o,
  output rv_lite_pkg::xword_t     instr_count_o
);

  rv_lite_pkg::phase_e  phase;
  rv_lite_pkg::xword_t  pc, next_pc;
  rv_lite_pkg::inst_t   inst;
  logic                 halt;

  // decode to register file
  logic [4:0]           rs1_addr, rs2_addr;
  rv_lite_pkg::xword_t  rs1_data, rs2_data, a0;

  // decode to execute
  rv_lite_pkg::alu_op_e alu_op;
  rv_lite_pkg::xword_t  op_a, op_b, br_a, br_b, target;
  logic                 is_branch, is_jal, br_ne;
  logic [4:0]           rd;
  logic                 rd_wen;

  // execute and commit
  rv_lite_pkg::xword_t  result, rf_wdata;
  logic                 rf_wen;

  fetch_unit i_fetch_unit (
    .clock       (clock),       .reset       (reset),
    .run_i       (run_i),       .halt_i      (halt),
    .imem_we_i   (imem_we_i),   .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i), .next_pc_i   (next_pc),
    .phase_o     (phase),       .pc_o        (pc),
    .inst_o      (inst)
  );

  decode_unit i_decode_unit (
    .clock       (clock),     .reset       (reset),
    .phase_i     (phase),     .pc_i        (pc),         .inst_i     (inst),
    .rs1_addr_o  (rs1_addr),  .rs2_addr_o  (rs2_addr),
    .rs1_data_i  (rs1_data),  .rs2_data_i  (rs2_data),
    .alu_op_o    (alu_op),    .op_a_o      (op_a),       .op_b_o     (op_b),
    .br_a_o      (br_a),      .br_b_o      (br_b),
    .is_branch_o (is_branch), .is_jal_o    (is_jal),     .br_ne_o    (br_ne),
    .target_o    (target),    .rd_o        (rd),         .rd_wen_o   (rd_wen)
  );

  regfile i_regfile (
    .clock      (clock),    .reset      (reset),
    .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
    .rd_i       (rd),       .rd_wen_i   (rf_wen),
    .rd_wdata_i (rf_wdata), .a0_o       (a0)
  );

  execute_unit i_execute_unit (
    .clock       (clock),     .reset    (reset),
    .phase_i     (phase),     .pc_i     (pc),       .alu_op_i (alu_op),
    .op_a_i      (op_a),      .op_b_i   (op_b),
    .br_a_i      (br_a),      .br_b_i   (br_b),
    .is_branch_i (is_branch), .is_jal_i (is_jal),   .br_ne_i  (br_ne),
    .target_i    (target),    .result_o (result),   .next_pc_o (next_pc)
  );

  commit_unit i_commit_unit (
    .clock          (clock),          .reset          (reset),
    .phase_i        (phase),          .pc_i           (pc),
    .inst_i         (inst),           .rd_i           (rd),
    .rd_wen_i       (rd_wen),         .result_i       (result),
    .a0_i           (a0),             .rf_wen_o       (rf_wen),
    .rf_wdata_o     (rf_wdata),       .halt_o         (halt),
    .commit_valid_o (commit_valid_o), .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),  .commit_wen_o   (commit_wen_o),
    .commit_wdest_o (commit_wdest_o), .commit_wdata_o (commit_wdata_o),
    .putch_valid_o  (putch_valid_o),  .putch_char_o   (putch_char_o),
    .trap_o         (trap_o),         .trap_code_o    (trap_code_o),
    .instr_count_o  (instr_count_o)
  );

endmodule

// File: dv/rv_lite_tb.sv
// rv_lite testbench running random programs on the core against an ISA model

`timescale 1ns/1ns

`include "rv_lite_consts.svh"

module rv_lite_tb;

  localparam int NUM_PROGS    = 6;
  localparam int BODY_LEN     = 40;
  localparam int PROG_LEN     = BODY_LEN + 2;
  localparam int RESET_CYCLES = 10;
  localparam int TAIL_CYCLES  = 20;
  // 60 instructions of 4 cycles per program with three times that for stalls and loading
  localparam int TIMEOUT_CYCLES = NUM_PROGS * 60 * 4 * 3;

  logic                   clock;
  logic                   reset;
  logic                   run_i;
  logic                   imem_we_i;
  logic [`RV_IMEM_AW-1:0] imem_addr_i;
  logic [31:0]            imem_data_i;
  logic                   commit_valid_o;
  logic [63:0]            commit_pc_o;
  logic [31:0]            commit_inst_o;
  logic                   commit_wen_o;
  logic [7:0]             commit_wdest_o;
  logic [63:0]            commit_wdata_o;
  logic                   putch_valid_o;
  logic [7:0]             putch_char_o;
  logic                   trap_o;
  logic [7:0]             trap_code_o;
  logic [63:0]            instr_count_o;

  // program image and reference model state
  logic [31:0] prog [PROG_LEN];
  logic [63:0] m_regs [32];
  logic [63:0] m_pc;
  int          m_count;

  integer seed = 32'h5cb6;
  int     mismatches;
  int     other_errors;
  int     commits_checked;
  int     low_edges;
  int     stall_left;
  int     cycle_count;
  bit     checking;
  bit     trap_seen;

  rv_lite_top i_rv_lite_top (
    .clock          (clock),          .reset          (reset),
    .run_i          (run_i),          .imem_we_i      (imem_we_i),
    .imem_addr_i    (imem_addr_i),    .imem_data_i    (imem_data_i),
    .commit_valid_o (commit_valid_o), .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),  .commit_wen_o   (commit_wen_o),
    .commit_wdest_o (commit_wdest_o), .commit_wdata_o (commit_wdata_o),
    .putch_valid_o  (putch_valid_o),  .putch_char_o   (putch_char_o),
    .trap_o         (trap_o),         .trap_code_o    (trap_code_o),
    .instr_count_o  (instr_count_o)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  function automatic logic [31:0] enc_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `RV_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic logic [31:0] random_inst(input int idx);
    int          kind;
    int          span;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [20:0] off;
    kind = urand(17);
    // x0 to x15 only so registers get reused and x0 shows up often
    rd   = 5'(urand(16));
    rs1  = 5'(urand(16));
    rs2  = 5'(urand(16));
    // forward jumps that land on the trap at the latest
    span = PROG_LEN - 1 - idx;
    if (span > 8) begin
      span = 8;
    end
    off = 21'((1 + urand(span)) * 4);
    case (kind)
      0:  return {20'(urand(1 << 20)), rd, `RV_OP_LUI};
      1:  return enc_jal(off, rd);
      2:  return enc_imm(12'(urand(4096)), rs1, 3'b000, rd);
      3:  return enc_imm(12'(urand(4096)), rs1, 3'b100, rd);
      4:  return enc_imm(12'(urand(4096)), rs1, 3'b110, rd);
      5:  return enc_imm(12'(urand(4096)), rs1, 3'b111, rd);
      6:  return enc_imm({6'b0, 6'(urand(64))}, rs1, 3'b001, rd);
      7:  return enc_reg(7'h00, rs2, rs1, 3'b000, rd);
      8:  return enc_reg(7'h20, rs2, rs1, 3'b000, rd);
      9:  return enc_reg(7'h00, rs2, rs1, 3'b111, rd);
      10: return enc_reg(7'h00, rs2, rs1, 3'b110, rd);
      11: return enc_reg(7'h00, rs2, rs1, 3'b100, rd);
      12: return enc_reg(7'h00, rs2, rs1, 3'b001, rd);
      13: return enc_reg(7'h00, rs2, rs1, 3'b101, rd);
      14: return enc_reg(7'h00, rs2, rs1, 3'b010, rd);
      15: return enc_branch(off[12:0], rs2, rs1, 3'b000);
      default: return enc_branch(off[12:0], rs2, rs1, 3'b001);
    endcase
  endfunction

  task automatic make_program();
    int i;
    for (i = 0; i < BODY_LEN; i++) begin
      prog[i] = random_inst(i);
    end
    prog[BODY_LEN]     = `RV_INST_PUTCH;
    prog[BODY_LEN + 1] = {25'd0, `RV_OP_TRAP};
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    run_i <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic load_program();
    int i;
    for (i = 0; i < PROG_LEN; i++) begin
      @(posedge clock);
      imem_we_i   <= 1'b1;
      imem_addr_i <= i[`RV_IMEM_AW-1:0];
      imem_data_i <= prog[i];
    end
    @(posedge clock);
    imem_we_i <= 1'b0;
  endtask

  task automatic start_model();
    int r;
    for (r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    m_pc      = `RV_PC_START;
    m_count   = 0;
    trap_seen = 1'b0;
  endtask

  // stalls come in bursts of 2 to 8 cycles
  task automatic drive_run(input bit allow_stall);
    if (stall_left > 0) begin
      stall_left--;
      run_i <= 1'b0;
    end else if (allow_stall && urand(8) == 0) begin
      stall_left = 1 + urand(7);
      run_i <= 1'b0;
    end else begin
      run_i <= 1'b1;
    end
  endtask

  // step the ISA model by one instruction and compare the commit record
  task automatic check_commit();
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] res;
    logic [63:0] npc;
    logic        wen;
    logic        is_trap;
    int          idx;
    idx = int'((m_pc - `RV_PC_START) >> 2);
    if (idx < 0 || idx >= PROG_LEN) begin
      $display("model pc %h is outside the loaded program", m_pc);
      other_errors++;
      return;
    end
    inst = prog[idx];
    rd   = inst[11:7];
    f3   = inst[14:12];
    a    = m_regs[inst[19:15]];
    b    = m_regs[inst[24:20]];
    imm  = {{52{inst[31]}}, inst[31:20]};
    res  = '0;
    npc  = m_pc + 64'd4;
    wen  = 1'b0;
    case (inst[6:0])
      `RV_OP_LUI: begin
        res = {{32{inst[31]}}, inst[31:12], 12'b0};
        wen = 1'b1;
      end
      `RV_OP_JAL: begin
        res = m_pc + 64'd4;
        npc = m_pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        wen = 1'b1;
      end
      `RV_OP_IMM: begin
        wen = 1'b1;
        case (f3)
          3'b000:  res = a + imm;
          3'b100:  res = a ^ imm;
          3'b110:  res = a | imm;
          3'b111:  res = a & imm;
          default: res = a << inst[25:20];
        endcase
      end
      `RV_OP_REG: begin
        wen = 1'b1;
        case (f3)
          3'b000:  res = inst[30] ? a - b : a + b;
          3'b111:  res = a & b;
          3'b110:  res = a | b;
          3'b100:  res = a ^ b;
          3'b001:  res = a << b[5:0];
          3'b101:  res = a >> b[5:0];
          default: res = {63'b0, $signed(a) < $signed(b)};
        endcase
      end
      `RV_OP_BRANCH: begin
        if (f3[0] ? (a != b) : (a == b)) begin
          npc = m_pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    // x0 is never written
    if (rd == 5'd0) begin
      wen = 1'b0;
    end
    is_trap = (inst[6:0] == `RV_OP_TRAP);
    m_count++;
    check_value("commit_pc_o", commit_pc_o, m_pc);
    check_value("commit_inst_o", 64'(commit_inst_o), 64'(inst));
    check_value("commit_wen_o", 64'(commit_wen_o), 64'(wen));
    if (wen) begin
      check_value("commit_wdest_o", 64'(commit_wdest_o), 64'(rd));
      check_value("commit_wdata_o", commit_wdata_o, res);
    end
    check_value("putch_valid_o", 64'(putch_valid_o), 64'(inst == `RV_INST_PUTCH));
    if (inst == `RV_INST_PUTCH) begin
      check_value("putch_char_o", 64'(putch_char_o), 64'(m_regs[10][7:0]));
    end
    check_value("trap_o", 64'(trap_o), 64'(is_trap));
    if (is_trap) begin
      check_value("trap_code_o", 64'(trap_code_o), 64'(m_regs[10][7:0]));
      check_value("instr_count_o", instr_count_o, 64'(m_count));
      trap_seen = 1'b1;
    end
    if (wen) begin
      m_regs[rd] = res;
    end
    m_pc = npc;
    commits_checked++;
  endtask

  // outputs sampled on the falling edge
  always @(negedge clock) begin
    if (checking) begin
      if (commit_valid_o) begin
        if (trap_seen) begin
          $display("commit at pc %h appeared at %0t ns after the trap", commit_pc_o, $time);
          other_errors++;
        end else begin
          // an instruction in flight needs at most 3 more edges to commit
          if (low_edges >= 4) begin
            $display("commit at pc %h appeared at %0t ns while run_i was held low",
                     commit_pc_o, $time);
            other_errors++;
          end
          check_commit();
        end
      end else begin
        check_value("putch_valid_o", 64'(putch_valid_o), 64'd0);
        check_value("trap_o", 64'(trap_o), 64'(trap_seen));
      end
    end
    // run_i as the DUT samples it at the next rising edge
    if (run_i) begin
      low_edges = 0;
    end else begin
      low_edges++;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the programs did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d value mismatches, %0d other errors, %0d commits checked",
             mismatches, other_errors + 1, commits_checked);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int p;
    reset           = 1'b1;
    run_i           = 1'b0;
    imem_we_i       = 1'b0;
    imem_addr_i     = '0;
    imem_data_i     = '0;
    checking        = 1'b0;
    trap_seen       = 1'b0;
    mismatches      = 0;
    other_errors    = 0;
    commits_checked = 0;
    low_edges       = 0;
    stall_left      = 0;
    for (p = 0; p < NUM_PROGS; p++) begin
      make_program();
      apply_reset();
      load_program();
      start_model();
      checking   = 1'b1;
      stall_left = 0;
      // the first program runs without stalls
      while (!trap_seen) begin
        @(posedge clock);
        drive_run(p != 0);
      end
      // run_i stays high so only the trap keeps the core from committing
      @(posedge clock);
      run_i <= 1'b1;
      repeat (TAIL_CYCLES) @(posedge clock);
      @(negedge clock);
      check_value("instr_count_o", instr_count_o, 64'(m_count));
      checking = 1'b0;
    end
    $display("errors: %0d value mismatches, %0d other errors, %0d commits checked",
             mismatches, other_errors, commits_checked);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: rv_lite_core.f
+incdir+include
hw/rv_lite_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/regfile.sv
hw/execute_unit.sv
hw/commit_unit.sv
hw/rv_lite_top.sv
dv/rv_lite_tb.sv
